// ==== pool_pkg.sv ====
package pool_pkg;

	// Word width of one channel value
	parameter int DATA_W = 16;

	// Largest window is 2**3 = 8 atoms
	parameter int MAX_WIN_SHIFT = 3;

	// Output counter width
	parameter int CNT_W = 16;

	// Pooling operation
	typedef enum logic {
		OP_MAX = 1'b0,	// Signed maximum over the window
		OP_AVE = 1'b1	// Signed sum shifted right by win_shift
	} pool_op_e;

	// Layer controller states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,	// Waiting for the first start
		ST_RUN   = 2'd1,	// Reading input words
		ST_DRAIN = 2'd2,	// Input done, waiting on the last writebacks
		ST_DONE  = 2'd3		// Layer finished, ready raised
	} eng_state_e;

	// Settings of one layer, latched on start
	typedef struct packed {
		pool_op_e         op;
		logic [1:0]       win_shift;	// Window is 2**win_shift atoms
		logic [CNT_W-1:0] out_count;	// Result atoms in the layer
	} pool_cfg_t;

endpackage

// ==== pool_cfg_regs.sv ====
`timescale 1ns/10ps

module pool_cfg_regs (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_start,		// One-cycle start pulse
	input  pool_pkg::pool_op_e         i_op,
	input  logic [1:0]                 i_win_shift,
	input  logic [pool_pkg::CNT_W-1:0] i_out_count,
	input  logic                       i_idle,		// Engine in ST_IDLE or ST_DONE
	output pool_pkg::pool_cfg_t        o_cfg,		// Settings held for the layer
	output logic                       o_cfg_load	// Layer start pulse
);

	import pool_pkg::*;

	logic accept;	// Start seen while the engine can take a new layer

	// A start landing on the load cycle itself is ignored
	assign accept = i_start && i_idle && !o_cfg_load;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_cfg      <= '{op: OP_MAX, win_shift: '0, out_count: '0};
			o_cfg_load <= 1'b0;
		end else begin
			o_cfg_load <= accept;	// High the cycle after start
			if (accept) begin
				// Sample the levels once, later input changes are ignored
				o_cfg <= '{
					op:        i_op,
					win_shift: i_win_shift,
					out_count: i_out_count
				};
			end
		end
	end

endmodule

// ==== pool_ctrl.sv ====
`timescale 1ns/10ps

module pool_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  pool_pkg::pool_cfg_t i_cfg,
	input  logic                i_cfg_load,		// Layer start from the config block
	input  logic                i_atom_valid,	// One atom collected
	input  logic                i_res_valid,	// One result atom produced
	input  logic                i_wb_busy,		// Writeback still running
	output logic                o_rd_en,		// DMA read request level
	output logic                o_idle,			// Can accept a new start
	output logic                o_ready			// Layer finished
);

	import pool_pkg::*;

	eng_state_e state, state_nxt;

	logic [MAX_WIN_SHIFT-1:0] atom_cnt;	// Atom index inside the current window
	logic [MAX_WIN_SHIFT-1:0] win_mask;	// Index of the last atom in a window
	logic [CNT_W-1:0]         win_cnt;	// Windows fully read so far
	logic [CNT_W-1:0]         res_cnt;	// Results handed to writeback
	logic                     win_end;	// This atom closes a window
	logic                     last_win;	// Current window is the last one
	logic                     drain_ok;	// All results out and writeback idle

	// Window of 2**win_shift atoms, mask = size - 1
	assign win_mask = ~({MAX_WIN_SHIFT{1'b1}} << i_cfg.win_shift);
	assign win_end  = i_atom_valid && (atom_cnt == win_mask);
	assign last_win = (win_cnt == i_cfg.out_count - CNT_W'(1));
	assign drain_ok = (res_cnt == i_cfg.out_count) && !i_wb_busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;	// Hold by default
		case (state)
			ST_IDLE, ST_DONE: begin
				if (i_cfg_load)
					state_nxt = ST_RUN;
			end
			ST_RUN: begin
				// Empty layer has nothing to read
				if (i_cfg.out_count == '0)
					state_nxt = ST_DRAIN;
				else if (win_end && last_win)
					state_nxt = ST_DRAIN;	// Last needed word already taken
			end
			ST_DRAIN: begin
				if (drain_ok)
					state_nxt = ST_DONE;
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	// Atom and window counters, only live while reading
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atom_cnt <= '0;
			win_cnt  <= '0;
		end else if (i_cfg_load) begin
			atom_cnt <= '0;
			win_cnt  <= '0;
		end else if (state == ST_RUN && i_atom_valid) begin
			if (win_end) begin
				atom_cnt <= '0;
				win_cnt  <= win_cnt + CNT_W'(1);
			end else begin
				atom_cnt <= atom_cnt + MAX_WIN_SHIFT'(1);
			end
		end
	end

	// Result counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			res_cnt <= '0;
		else if (i_cfg_load)
			res_cnt <= '0;
		else if (i_res_valid)
			res_cnt <= res_cnt + CNT_W'(1);
	end

	assign o_rd_en = (state == ST_RUN);
	assign o_idle  = (state == ST_IDLE) || (state == ST_DONE);
	assign o_ready = (state == ST_DONE);	// Held until the next layer starts

endmodule

// ==== atom_deser.sv ====
`timescale 1ns/10ps

module atom_deser #(
	parameter int LANES = 8
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                i_clear,		// Layer start, restarts the burst
	input  logic                                i_rd_we,		// DMA word strobe
	input  logic [pool_pkg::DATA_W-1:0]         i_rd_data,
	output logic                                o_atom_valid,	// Full atom on o_atom_data
	output logic [LANES*pool_pkg::DATA_W-1:0]   o_atom_data		// Lane 0 in the low word
);

	import pool_pkg::*;

	localparam int CW = $clog2(LANES);

	logic [LANES*DATA_W-1:0] sbuf;		// Shift buffer, newest word on top
	logic [CW-1:0]           burst_cnt;	// Words in the current atom

	// Payload shift, first word ends in lane 0 after LANES shifts
	always_ff @(posedge clk) begin
		if (i_rd_we)
			sbuf <= {i_rd_data, sbuf[LANES*DATA_W-1:DATA_W]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			burst_cnt    <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= 1'b0;
			if (i_clear) begin
				burst_cnt <= '0;
			end else if (i_rd_we) begin
				if (burst_cnt == CW'(LANES - 1)) begin
					burst_cnt    <= '0;
					o_atom_valid <= 1'b1;	// Atom complete next cycle
				end else begin
					burst_cnt <= burst_cnt + CW'(1);
				end
			end
		end
	end

	assign o_atom_data = sbuf;

endmodule

// ==== pool_lanes.sv ====
`timescale 1ns/10ps

module pool_lanes #(
	parameter int LANES = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_clear,		// Layer start
	input  pool_pkg::pool_cfg_t               i_cfg,
	input  logic                              i_atom_valid,
	input  logic [LANES*pool_pkg::DATA_W-1:0] i_atom_data,
	output logic                              o_res_valid,	// One result atom ready
	output logic [LANES*pool_pkg::DATA_W-1:0] o_res_data
);

	import pool_pkg::*;

	// Room for the sum of 8 words
	localparam int ACC_W = DATA_W + MAX_WIN_SHIFT;

	logic [MAX_WIN_SHIFT-1:0] atom_cnt;	// Atom index inside the window
	logic [MAX_WIN_SHIFT-1:0] win_mask;	// Index of the last atom
	logic                     first;	// Atom opens a window
	logic                     last;		// Atom closes a window

	assign win_mask = ~({MAX_WIN_SHIFT{1'b1}} << i_cfg.win_shift);
	assign first    = (atom_cnt == '0);
	assign last     = (atom_cnt == win_mask);

	// Window position and result strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atom_cnt    <= '0;
			o_res_valid <= 1'b0;
		end else begin
			o_res_valid <= i_atom_valid && last && !i_clear;
			if (i_clear)
				atom_cnt <= '0;
			else if (i_atom_valid)
				atom_cnt <= last ? '0 : atom_cnt + MAX_WIN_SHIFT'(1);
		end
	end

	genvar g;
	generate
		for (g = 0; g < LANES; g++) begin : g_lane
			logic signed [ACC_W-1:0] lane_in;	// Sign extended input word
			logic signed [ACC_W-1:0] acc;		// Running max or sum
			logic signed [ACC_W-1:0] acc_nxt;
			logic signed [ACC_W-1:0] avg;		// Floor of sum / window

			assign lane_in = ACC_W'($signed(i_atom_data[g*DATA_W +: DATA_W]));

			always_comb begin
				if (first)
					acc_nxt = lane_in;	// Window restarts on its first atom
				else if (i_cfg.op == OP_MAX)
					acc_nxt = (lane_in > acc) ? lane_in : acc;
				else
					acc_nxt = acc + lane_in;
			end

			// Arithmetic shift rounds toward minus infinity
			assign avg = acc_nxt >>> i_cfg.win_shift;

			always_ff @(posedge clk) begin
				if (i_atom_valid) begin
					acc <= acc_nxt;
					if (last) begin
						// Max always fits in DATA_W, average is truncated
						o_res_data[g*DATA_W +: DATA_W] <= (i_cfg.op == OP_MAX) ?
							acc_nxt[DATA_W-1:0] : avg[DATA_W-1:0];
					end
				end
			end
		end
	endgenerate

endmodule

// ==== wb_serializer.sv ====
`timescale 1ns/10ps

module wb_serializer #(
	parameter int LANES = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_res_valid,	// Result atom strobe
	input  logic [LANES*pool_pkg::DATA_W-1:0] i_res_data,
	output logic                              o_wr_en,		// DMA write strobe
	output logic [pool_pkg::DATA_W-1:0]       o_wr_data,
	output logic                              o_busy		// Lanes still being written
);

	import pool_pkg::*;

	localparam int CW = $clog2(LANES);

	logic [LANES*DATA_W-1:0] wb_buf;	// Captured result, lane under write in low word
	logic [CW-1:0]           lane_cnt;	// Writeback count within the atom
	logic                    busy;

	// Payload, load on result then shift one lane down per write
	always_ff @(posedge clk) begin
		if (i_res_valid)
			wb_buf <= i_res_data;
		else if (busy)
			wb_buf <= {{DATA_W{1'b0}}, wb_buf[LANES*DATA_W-1:DATA_W]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy     <= 1'b0;
			lane_cnt <= '0;
		end else if (i_res_valid) begin
			busy     <= 1'b1;	// Writes start the next cycle with lane 0
			lane_cnt <= '0;
		end else if (busy) begin
			if (lane_cnt == CW'(LANES - 1)) begin
				busy     <= 1'b0;	// Last lane written
				lane_cnt <= '0;
			end else begin
				lane_cnt <= lane_cnt + CW'(1);
			end
		end
	end

	assign o_wr_en   = busy;
	assign o_wr_data = wb_buf[DATA_W-1:0];
	assign o_busy    = busy;

endmodule

// ==== pool_engine.sv ====
`timescale 1ns/10ps

module pool_engine #(
	parameter int LANES = 8		// Channels per atom
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_start,
	input  pool_pkg::pool_op_e         i_op,
	input  logic [1:0]                 i_win_shift,
	input  logic [pool_pkg::CNT_W-1:0] i_out_count,
	input  logic                       i_rd_we,		// DMA read data strobe
	input  logic [pool_pkg::DATA_W-1:0] i_rd_data,
	output logic                       o_rd_en,
	output logic                       o_wr_en,		// DMA write strobe, no acknowledge
	output logic [pool_pkg::DATA_W-1:0] o_wr_data,
	output logic                       o_ready
);

	import pool_pkg::*;

	pool_cfg_t               cfg;
	logic                    cfg_load;
	logic                    idle;
	logic                    atom_valid;
	logic [LANES*DATA_W-1:0] atom_data;
	logic                    res_valid;
	logic [LANES*DATA_W-1:0] res_data;
	logic                    wb_busy;

	pool_cfg_regs u_cfg (
		.clk         (clk),
		.rst         (rst),
		.i_start     (i_start),
		.i_op        (i_op),
		.i_win_shift (i_win_shift),
		.i_out_count (i_out_count),
		.i_idle      (idle),
		.o_cfg       (cfg),
		.o_cfg_load  (cfg_load)
	);

	pool_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.i_cfg        (cfg),
		.i_cfg_load   (cfg_load),
		.i_atom_valid (atom_valid),
		.i_res_valid  (res_valid),
		.i_wb_busy    (wb_busy),
		.o_rd_en      (o_rd_en),
		.o_idle       (idle),
		.o_ready      (o_ready)
	);

	atom_deser #(.LANES(LANES)) u_deser (
		.clk          (clk),
		.rst          (rst),
		.i_clear      (cfg_load),
		.i_rd_we      (i_rd_we),
		.i_rd_data    (i_rd_data),
		.o_atom_valid (atom_valid),
		.o_atom_data  (atom_data)
	);

	pool_lanes #(.LANES(LANES)) u_lanes (
		.clk          (clk),
		.rst          (rst),
		.i_clear      (cfg_load),
		.i_cfg        (cfg),
		.i_atom_valid (atom_valid),
		.i_atom_data  (atom_data),
		.o_res_valid  (res_valid),
		.o_res_data   (res_data)
	);

	wb_serializer #(.LANES(LANES)) u_wb (
		.clk         (clk),
		.rst         (rst),
		.i_res_valid (res_valid),
		.i_res_data  (res_data),
		.o_wr_en     (o_wr_en),
		.o_wr_data   (o_wr_data),
		.o_busy      (wb_busy)
	);

endmodule

// ==== tb_pool_ref.svh ====
`ifndef TB_POOL_REF_SVH
`define TB_POOL_REF_SVH

// Expected word for one lane of one result atom, taken from the stored input words
function automatic logic [DATA_W-1:0] ref_pool(input pool_op_e op, input int win_shift,
		input int out_idx, input int lane);
	int win;
	int base;
	int val;
	int acc;
	int a;
	win  = 1 << win_shift;
	base = out_idx * win * LANES;	// First word of this window
	acc  = 0;
	for (a = 0; a < win; a++) begin
		val = $signed(in_words[base + a * LANES + lane]);	// Sign extended to int
		if (a == 0)
			acc = val;
		else if (op == OP_MAX)
			acc = (val > acc) ? val : acc;
		else
			acc = acc + val;
	end
	if (op == OP_AVE)
		acc = acc >>> win_shift;	// Floor of sum / window
	return acc[DATA_W-1:0];
endfunction

task automatic check_val(input string name, input logic [DATA_W-1:0] exp_val,
		input logic [DATA_W-1:0] act_val);
	if (exp_val !== act_val) begin
		mismatch_cnt++;
		$display("Mismatch in %s: expected %h, actual %h", name, exp_val, act_val);
	end
endtask

task automatic report_fail(input string msg);
	fail_cnt++;
	$display("Error in %s: %s", test_name, msg);
endtask

// Random input words for one layer and the expected write sequence
task automatic build_layer(input pool_op_e op, input int win_shift, input int out_count);
	int total;
	int i;
	int o;
	int l;
	logic [31:0] r;
	logic [DATA_W-1:0] word;
	in_words.delete();
	stim_q.delete();
	exp_q.delete();
	exp_idx = 0;
	total = out_count * (1 << win_shift) * LANES;
	for (i = 0; i < total; i++) begin
		r = $urandom;
		// Small values around zero hit the rounding, the rest is full range
		word = r[31] ? ({12'd0, r[3:0]} - 16'd8) : r[15:0];
		in_words.push_back(word);
		stim_q.push_back(word);
	end
	for (o = 0; o < out_count; o++)
		for (l = 0; l < LANES; l++)
			exp_q.push_back(ref_pool(op, win_shift, o, l));	// Lane 0 first
endtask

`endif

// ==== tb_pool_engine.sv ====
`timescale 1ns/10ps

module tb_pool_engine;

	import pool_pkg::*;

	localparam int LANES = 4;

	// Atoms per test, out_count * window, summed over all layers below
	localparam int ATOMS_TOTAL = 5 * 4 + 6 * 1 + 5 * 2 + 3 * 8 + 4 * 2;
	localparam int WATCHDOG_CYCLES = ATOMS_TOTAL * LANES * 3 + 200;

	logic               clk = 1'b0;
	logic               rst;
	logic               i_start;
	pool_op_e           i_op;
	logic [1:0]         i_win_shift;
	logic [CNT_W-1:0]   i_out_count;
	logic               i_rd_we = 1'b0;		// Driven by the DMA model
	logic [DATA_W-1:0]  i_rd_data = '0;
	logic               o_rd_en;
	logic               o_wr_en;
	logic [DATA_W-1:0]  o_wr_data;
	logic               o_ready;

	logic [DATA_W-1:0]  in_words[$];	// Words of the current layer, kept for the reference
	logic [DATA_W-1:0]  stim_q[$];		// Words still to be sent by the DMA
	logic [DATA_W-1:0]  exp_q[$];		// Expected writes in order
	int                 exp_idx;		// Next expected write
	int                 mismatch_cnt = 0;
	int                 fail_cnt = 0;
	int                 gap = 0;		// Idle cycles before the next DMA word
	int                 since_last = 0;	// Cycles since the last word of the layer
	logic               rd_late_seen = 1'b0;
	string              test_name = "init";
	int unsigned        seed;

	`include "tb_pool_ref.svh"

	pool_engine #(.LANES(LANES)) u_dut (
		.clk         (clk),
		.rst         (rst),
		.i_start     (i_start),
		.i_op        (i_op),
		.i_win_shift (i_win_shift),
		.i_out_count (i_out_count),
		.i_rd_we     (i_rd_we),
		.i_rd_data   (i_rd_data),
		.o_rd_en     (o_rd_en),
		.o_wr_en     (o_wr_en),
		.o_wr_data   (o_wr_data),
		.o_ready     (o_ready)
	);

	always #5 clk = ~clk;

	// DMA read model with random gaps of 0 to 2 cycles
	always @(negedge clk) begin
		i_rd_we = 1'b0;
		if (o_rd_en && stim_q.size() > 0) begin
			if (gap == 0) begin
				i_rd_we    = 1'b1;
				i_rd_data  = stim_q.pop_front();
				gap        = $urandom_range(2, 0);
				since_last = 0;
			end else begin
				gap--;
			end
		end else if (stim_q.size() == 0) begin
			since_last++;
			// Read request must be gone two cycles after the last word
			if (o_rd_en && since_last >= 2 && !rd_late_seen) begin
				rd_late_seen = 1'b1;
				report_fail("o_rd_en still high after the last input word");
			end
		end
	end

	// Write monitor
	always @(negedge clk) begin
		if (!rst && o_wr_en) begin
			if (exp_idx >= exp_q.size()) begin
				report_fail($sformatf("extra write of %h", o_wr_data));
			end else begin
				check_val($sformatf("%s word %0d", test_name, exp_idx), exp_q[exp_idx], o_wr_data);
			end
			exp_idx++;
		end
	end

	task automatic print_counts();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
	endtask

	task automatic run_layer(input string name, input pool_op_e op, input int win_shift,
			input int out_count, input bit poke_start);
		int budget;
		int cyc;
		test_name    = name;
		rd_late_seen = 1'b0;
		build_layer(op, win_shift, out_count);
		budget = out_count * (1 << win_shift) * LANES * 3 + 20;
		i_start     = 1'b1;
		i_op        = op;
		i_win_shift = win_shift[1:0];
		i_out_count = out_count[CNT_W-1:0];
		@(negedge clk);
		i_start = 1'b0;
		// New levels that the latched settings must ignore
		i_op        = (op == OP_MAX) ? OP_AVE : OP_MAX;
		i_win_shift = ~win_shift[1:0];
		i_out_count = out_count[CNT_W-1:0] + 16'd3;
		@(negedge clk);	// cfg_load went by, state is now ST_RUN
		if (o_ready)
			report_fail("o_ready still high after start");
		if (!o_rd_en)
			report_fail("o_rd_en did not rise after start");
		cyc = 0;
		while (!o_ready && cyc < budget) begin
			i_start = poke_start && (cyc == 4);	// Start during a run is ignored
			@(negedge clk);
			cyc++;
		end
		i_start = 1'b0;
		if (!o_ready) begin
			report_fail("o_ready did not rise");
		end else begin
			if (exp_idx != exp_q.size())
				report_fail($sformatf("%0d writes seen, %0d expected", exp_idx, exp_q.size()));
			if (stim_q.size() != 0)
				report_fail("input words left unread");
		end
		// Ready holds and the read side stays quiet
		repeat (LANES + 2) begin
			@(negedge clk);
			if (!o_ready)
				report_fail("o_ready dropped without a new start");
			if (o_rd_en)
				report_fail("o_rd_en rose after the layer ended");
		end
	endtask

	initial begin
		seed = 32'h2f39146d;
		void'($urandom(seed));
		rst         = 1'b1;
		i_start     = 1'b0;
		i_op        = OP_MAX;
		i_win_shift = '0;
		i_out_count = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		test_name = "reset";
		repeat (6) begin
			@(negedge clk);
			check_val("reset o_rd_en", '0, o_rd_en);
			check_val("reset o_wr_en", '0, o_wr_en);
			check_val("reset o_ready", '0, o_ready);
		end
		run_layer("max_w4", OP_MAX, 2, 5, 1'b0);
		run_layer("ave_w1", OP_AVE, 0, 6, 1'b0);	// Back to back with a new operation
		run_layer("ave_w2", OP_AVE, 1, 5, 1'b0);
		run_layer("ave_w8", OP_AVE, 3, 3, 1'b1);
		run_layer("max_w2", OP_MAX, 1, 4, 1'b0);
		print_counts();
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
		print_counts();
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
pool_pkg.sv
pool_cfg_regs.sv
pool_ctrl.sv
atom_deser.sv
pool_lanes.sv
wb_serializer.sv
pool_engine.sv
tb_pool_engine.sv
